//--- files.f
+incdir+hdl
hdl/vic_pkg.sv
hdl/dot_timing.sv
hdl/pixel_shifter.sv
hdl/mode_color_decoder.sv
hdl/sprite_priority_mux.sv
hdl/border_mask.sv
hdl/pixel_sequencer_top.sv
tests/pixel_sequencer_properties.sv
tests/pixel_sequencer_tb.sv

//--- tests/pixel_sequencer_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "vic_settings.svh"

module pixel_sequencer_tb import vic_pkg::*; ();

    localparam int NUM_ROWS    = 20;
    localparam int WATCHDOG_NS = NUM_ROWS * 6 * 32 * 10 + 2000;

    typedef struct packed {
        mode_t       mode;
        logic [2:0]  xscroll;
        bg_colors_t  bg;
        color_t      ec;
        logic        border;
        sprite_bus_t sprite;
        fetch_t      fetch;
    } row_t;

    logic        clk_dot4x;
    logic        rst;
    mode_t       mode_i;
    logic [2:0]  xscroll_i;
    logic [6:0]  cycle_num_i;
    bg_colors_t  bg_i;
    color_t      ec_i;
    logic        border_i;
    sprite_bus_t sprite_i;
    logic        fetch_strobe_i;
    fetch_t      fetch_i;
    color_t      pixel_o;
    logic        pixel_valid_o;

    row_t        rows [NUM_ROWS];
    string       names [NUM_ROWS];
    logic [31:0] expected [NUM_ROWS];
    int          row_count;
    int          pixel_errors;
    int          timing_errors;
    int          tick_count;
    int          since_valid;
    logic        seen_valid;
    logic [31:0] lfsr_state;

    pixel_sequencer_top UUT (
        .clk_dot4x      (clk_dot4x),
        .rst            (rst),
        .mode_i         (mode_i),
        .xscroll_i      (xscroll_i),
        .cycle_num_i    (cycle_num_i),
        .bg_i           (bg_i),
        .ec_i           (ec_i),
        .border_i       (border_i),
        .sprite_i       (sprite_i),
        .fetch_strobe_i (fetch_strobe_i),
        .fetch_i        (fetch_i),
        .pixel_o        (pixel_o),
        .pixel_valid_o  (pixel_valid_o)
    );

    always #5 clk_dot4x = ~clk_dot4x;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_random(input int nbits, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic color_t pick4(input logic [1:0] code, input color_t c0,
                                     input color_t c1, input color_t c2, input color_t c3);
        return (code == 2'd0) ? c0 : (code == 2'd1) ? c1 : (code == 2'd2) ? c2 : c3;
    endfunction

    // b0c sits in the top nibble
    function automatic color_t bg_pick(input bg_colors_t bg, input logic [1:0] idx);
        return bg[15 - 4 * idx -: 4];
    endfunction

    // reference model, eight dots of one cell starting at the load dot
    function automatic logic [31:0] expected_sequence(input row_t r);
        logic [31:0] seq;
        logic [11:0] cw;
        logic        mc_cell;
        logic        illegal;
        logic [1:0]  code;
        logic [1:0]  sp;
        logic        bgnd;
        color_t      base;
        color_t      c;
        color_t      own;
        seq = '0;
        cw = r.fetch.char_word;
        illegal = r.mode[2] && (r.mode[1] || r.mode[0]);
        mc_cell = r.mode[0] && (r.mode[1] || r.mode[2] || cw[11]);
        for (int d = 0; d < 8; d++) begin
            if (mc_cell) begin
                code = r.fetch.pixels[7 - 2 * (d / 2) -: 2];
            end else begin
                code = {2{r.fetch.pixels[7 - d]}};
            end
            bgnd = !code[1];
            if (illegal) begin
                base = `BLACK;
            end else if (r.mode[2]) begin
                base = code[1] ? cw[11:8] : bg_pick(r.bg, cw[7:6]);
            end else if (r.mode[1]) begin
                base = mc_cell ? pick4(code, r.bg.b0c, cw[7:4], cw[3:0], cw[11:8])
                               : (code[1] ? cw[7:4] : cw[3:0]);
            end else begin
                base = mc_cell ? pick4(code, r.bg.b0c, r.bg.b1c, r.bg.b2c, {1'b0, cw[10:8]})
                               : (code[1] ? cw[11:8] : r.bg.b0c);
            end
            c = base;
            // sprite 0 is visited last and wins
            for (int n = `NUM_SPRITES - 1; n >= 0; n--) begin
                sp  = r.sprite.cur_pixel[2 * n +: 2];
                own = r.sprite.col[`COLOR_W * n +: `COLOR_W];
                if (!r.sprite.pri[n] || bgnd) begin
                    if (r.sprite.mmc[n] && sp != 2'b00) begin
                        c = pick4(sp, c, r.sprite.mc0, own, r.sprite.mc1);
                    end else if (!r.sprite.mmc[n] && sp[1]) begin
                        c = own;
                    end
                end
                if (r.sprite.pri[n] && !bgnd && sp[1]) begin
                    c = base;
                end
            end
            if (r.border) begin
                c = r.ec;
            end
            seq[31 - 4 * d -: 4] = c;
        end
        return seq;
    endfunction

    function automatic logic rotation_matches(input logic [31:0] exp_seq,
                                              input logic [31:0] actual);
        logic [31:0] rotated;
        logic        found;
        found = 1'b0;
        rotated = exp_seq;
        for (int k = 0; k < 8; k++) begin
            if (rotated == actual) begin
                found = 1'b1;
            end
            rotated = {rotated[27:0], rotated[31:28]};
        end
        return found;
    endfunction

    function automatic sprite_bus_t add_sprite(input sprite_bus_t s, input int n,
                                               input logic pri, input logic mmc,
                                               input logic [1:0] code, input color_t col);
        sprite_bus_t t;
        t = s;
        t.cur_pixel[2 * n +: 2] = code;
        t.pri[n] = pri;
        t.mmc[n] = mmc;
        t.col[`COLOR_W * n +: `COLOR_W] = col;
        return t;
    endfunction

    function automatic row_t make_row(input mode_t mode, input logic [2:0] xscroll,
                                      input color_t ec, input logic border,
                                      input sprite_bus_t sprite, input logic [7:0] pixels,
                                      input logic [11:0] cw);
        row_t r;
        r.mode = mode;
        r.xscroll = xscroll;
        r.bg = {4'h6, 4'h2, 4'h8, 4'h9};
        r.ec = ec;
        r.border = border;
        r.sprite = sprite;
        r.fetch.pixels = pixels;
        r.fetch.char_word = cw;
        return r;
    endfunction

    task automatic put_row(input string name, input row_t r);
        names[row_count] = name;
        rows[row_count] = r;
        expected[row_count] = expected_sequence(r);
        row_count++;
    endtask

    task automatic build_table();
        sprite_bus_t none;
        sprite_bus_t sp;
        logic [31:0] rnd_pix;
        logic [31:0] rnd_cw;
        logic [11:0] rnd_modes;
        none = '0;
        none.mc0 = 4'hA;
        none.mc1 = 4'hC;
        put_row("std_char", make_row(`MODE_STANDARD_CHAR, 0, 4'hE, 0, none, 8'hB2, 12'h1A3));
        put_row("std_bitmap", make_row(`MODE_STANDARD_BITMAP, 3, 4'hE, 0, none, 8'hC5, 12'h0B4));
        put_row("mc_char", make_row(`MODE_MULTICOLOR_CHAR, 5, 4'hE, 0, none, 8'h1B, 12'hD35));
        put_row("mc_char_hires",
                make_row(`MODE_MULTICOLOR_CHAR, 2, 4'hE, 0, none, 8'h96, 12'h3C1));
        put_row("mc_bitmap", make_row(`MODE_MULTICOLOR_BITMAP, 7, 4'hE, 0, none, 8'hE4, 12'hE7C));
        put_row("ecm_b3c", make_row(`MODE_EXTENDED_BG_COLOR, 1, 4'hE, 0, none, 8'h3A, 12'h4C0));
        put_row("ecm_b1c", make_row(`MODE_EXTENDED_BG_COLOR, 4, 4'hE, 0, none, 8'h3A, 12'h74A));
        put_row("inv_ecm_mc_char",
                make_row(`MODE_INV_ECM_MC_CHAR, 6, 4'hE, 0, none, 8'hA5, 12'hFFF));
        put_row("inv_ecm_std_bitmap",
                make_row(`MODE_INV_ECM_STD_BITMAP, 0, 4'hE, 0, none, 8'hA5, 12'hFFF));
        put_row("inv_ecm_mc_bitmap",
                make_row(`MODE_INV_ECM_MC_BITMAP, 3, 4'hE, 0, none, 8'hA5, 12'hFFF));
        sp = add_sprite(none, 2, 1'b0, 1'b0, 2'b10, 4'h7);
        put_row("spr_front", make_row(`MODE_STANDARD_CHAR, 2, 4'hE, 0, sp, 8'hF0, 12'h155));
        sp = add_sprite(none, 3, 1'b1, 1'b0, 2'b10, 4'hD);
        put_row("spr_behind", make_row(`MODE_STANDARD_CHAR, 5, 4'hE, 0, sp, 8'h3C, 12'h155));
        sp = add_sprite(none, 1, 1'b1, 1'b0, 2'b10, 4'hB);
        sp = add_sprite(sp, 4, 1'b0, 1'b0, 2'b11, 4'h3);
        put_row("spr_restore", make_row(`MODE_STANDARD_CHAR, 1, 4'hE, 0, sp, 8'h5A, 12'h155));
        // mc0 on background, mc1 on foreground
        sp = add_sprite(none, 0, 1'b1, 1'b1, 2'b01, 4'h4);
        sp = add_sprite(sp, 5, 1'b0, 1'b1, 2'b11, 4'h4);
        put_row("spr_mc", make_row(`MODE_STANDARD_CHAR, 6, 4'hE, 0, sp, 8'h0F, 12'h255));
        sp = add_sprite(none, 3, 1'b0, 1'b1, 2'b10, 4'h5);
        sp = add_sprite(sp, 7, 1'b0, 1'b1, 2'b00, 4'h1);
        put_row("spr_mc_own", make_row(`MODE_STANDARD_CHAR, 7, 4'hE, 0, sp, 8'h69, 12'h255));
        sp = add_sprite(none, 2, 1'b0, 1'b0, 2'b10, 4'h7);
        put_row("border", make_row(`MODE_MULTICOLOR_BITMAP, 4, 4'hF, 1, sp, 8'hE4, 12'hE7C));
        rnd_modes = {`MODE_MULTICOLOR_CHAR, `MODE_MULTICOLOR_BITMAP,
                     `MODE_EXTENDED_BG_COLOR, `MODE_STANDARD_BITMAP};
        for (int k = 0; k < 4; k++) begin
            take_random(8, rnd_pix);
            take_random(12, rnd_cw);
            put_row($sformatf("random_%0d", k),
                    make_row(rnd_modes[9 - 3 * k +: 3], k + 1, 4'hE, 0, none,
                             rnd_pix[7:0], rnd_cw[11:0]));
        end
    endtask

    // one clock, inputs change 1 ns after the edge, valid spacing tracked
    task automatic tick();
        @(posedge clk_dot4x);
        #1;
        fetch_strobe_i = (tick_count % 32 == 3);
        tick_count++;
        since_valid++;
        if (pixel_valid_o) begin
            if (seen_valid && since_valid != 4) begin
                $display("Error valid_spacing: expected 4 actual %0d", since_valid);
                timing_errors++;
            end
            seen_valid = 1'b1;
            since_valid = 0;
        end
    endtask

    task automatic apply_row(input int idx);
        logic [31:0] actual;
        int          got;
        mode_i = rows[idx].mode;
        xscroll_i = rows[idx].xscroll;
        bg_i = rows[idx].bg;
        ec_i = rows[idx].ec;
        border_i = rows[idx].border;
        sprite_i = rows[idx].sprite;
        fetch_i = rows[idx].fetch;
        // four cells so the pipeline settles on the new levels
        repeat (4 * 32) tick();
        got = 0;
        actual = '0;
        while (got < 8) begin
            tick();
            if (pixel_valid_o) begin
                actual[31 - 4 * got -: 4] = pixel_o;
                got++;
            end
        end
        if (!rotation_matches(expected[idx], actual)) begin
            $display("Error %s: expected %h (any rotation) actual %h",
                     names[idx], expected[idx], actual);
            pixel_errors++;
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all rows were checked");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        clk_dot4x = 1'b0;
        rst = 1'b1;
        mode_i = `MODE_STANDARD_CHAR;
        xscroll_i = 3'd0;
        cycle_num_i = 7'd30;
        bg_i = '0;
        ec_i = '0;
        border_i = 1'b0;
        sprite_i = '0;
        fetch_strobe_i = 1'b0;
        fetch_i = '0;
        row_count = 0;
        pixel_errors = 0;
        timing_errors = 0;
        tick_count = 0;
        since_valid = 0;
        seen_valid = 1'b0;
        lfsr_state = 32'hb788;
        build_table();
        repeat (16) begin
            tick();
            if (pixel_valid_o !== 1'b0) begin
                $display("Error reset_quiet: expected 0 actual %b", pixel_valid_o);
                timing_errors++;
            end
        end
        rst = 1'b0;
        tick();
        if (pixel_valid_o !== 1'b0) begin
            $display("Error after_reset_quiet: expected 0 actual %b", pixel_valid_o);
            timing_errors++;
        end
        for (int i = 0; i < row_count; i++) begin
            apply_row(i);
        end
        $display("pixel errors: %0d, timing errors: %0d, assertion failures: %0d",
                 pixel_errors, timing_errors, UUT.u_props.failures);
        if (pixel_errors + timing_errors + UUT.u_props.failures == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/pixel_sequencer_properties.sv
`timescale 1ns/1ns
`default_nettype none

module pixel_sequencer_properties (
    input wire clk_dot4x,
    input wire rst,
    input wire pixel_valid_i,
    input wire s0_valid_i,
    input wire s1_valid_i
);

    int failures = 0;

    // at most one pixel per dot
    a_no_back_to_back: assert property (@(posedge clk_dot4x) disable iff (rst)
        pixel_valid_i |=> !pixel_valid_i)
    else begin
        $error("pixel_valid_o high on two consecutive cycles");
        failures++;
    end

    // first cycle with rst low still has no pixel
    a_quiet_after_reset: assert property (@(posedge clk_dot4x)
        $fell(rst) |=> !pixel_valid_i)
    else begin
        $error("pixel_valid_o high in the cycle after reset");
        failures++;
    end

    // stage 1 answers stage 0 one cycle later
    a_stage1_follows: assert property (@(posedge clk_dot4x) disable iff (rst)
        s0_valid_i |=> s1_valid_i)
    else begin
        $error("s1_valid did not follow s0_valid");
        failures++;
    end

endmodule

bind pixel_sequencer_top pixel_sequencer_properties u_props (
    .clk_dot4x     (clk_dot4x),
    .rst           (rst),
    .pixel_valid_i (pixel_valid_o),
    .s0_valid_i    (s0_valid),
    .s1_valid_i    (s1_valid)
);

`default_nettype wire

//--- hdl/pixel_sequencer_top.sv
`timescale 1ns/1ns
`default_nettype none

module pixel_sequencer_top import vic_pkg::*; (
    input  wire              clk_dot4x,
    input  wire              rst,
    input  wire mode_t       mode_i,
    input  wire [2:0]        xscroll_i,
    input  wire [6:0]        cycle_num_i,
    input  wire bg_colors_t  bg_i,
    input  wire color_t      ec_i,
    input  wire              border_i,
    input  wire sprite_bus_t sprite_i,
    input  wire              fetch_strobe_i,
    input  wire fetch_t      fetch_i,
    output color_t           pixel_o,
    output logic             pixel_valid_o
);

    logic         dot_load;
    logic         dot_shift;
    logic [2:0]   xpos;
    shift_stage_t s0;
    logic         s0_valid;
    color_stage_t s1;
    logic         s1_valid;
    color_stage_t s2;
    logic         s2_valid;

    dot_timing u_dot_timing (
        .clk_dot4x   (clk_dot4x),
        .rst         (rst),
        .dot_load_o  (dot_load),
        .dot_shift_o (dot_shift),
        .xpos_o      (xpos)
    );

    pixel_shifter u_pixel_shifter (
        .clk_dot4x      (clk_dot4x),
        .rst            (rst),
        .dot_load_i     (dot_load),
        .dot_shift_i    (dot_shift),
        .xpos_i         (xpos),
        .cycle_num_i    (cycle_num_i),
        .xscroll_i      (xscroll_i),
        .mode_i         (mode_i),
        .fetch_strobe_i (fetch_strobe_i),
        .fetch_i        (fetch_i),
        .border_i       (border_i),
        .s0_o           (s0),
        .s0_valid_o     (s0_valid)
    );

    mode_color_decoder u_mode_color_decoder (
        .clk_dot4x  (clk_dot4x),
        .rst        (rst),
        .s0_i       (s0),
        .s0_valid_i (s0_valid),
        .mode_i     (mode_i),
        .bg_i       (bg_i),
        .s1_o       (s1),
        .s1_valid_o (s1_valid)
    );

    sprite_priority_mux u_sprite_priority_mux (
        .clk_dot4x  (clk_dot4x),
        .rst        (rst),
        .s1_i       (s1),
        .s1_valid_i (s1_valid),
        .mode_i     (mode_i),
        .sprite_i   (sprite_i),
        .s2_o       (s2),
        .s2_valid_o (s2_valid)
    );

    border_mask u_border_mask (
        .clk_dot4x     (clk_dot4x),
        .rst           (rst),
        .s2_i          (s2),
        .s2_valid_i    (s2_valid),
        .ec_i          (ec_i),
        .pixel_o       (pixel_o),
        .pixel_valid_o (pixel_valid_o)
    );

endmodule

`default_nettype wire

//--- hdl/border_mask.sv
`timescale 1ns/1ns
`default_nettype none

module border_mask import vic_pkg::*; (
    input  wire               clk_dot4x,
    input  wire               rst,
    input  wire color_stage_t s2_i,
    input  wire               s2_valid_i,
    input  wire color_t       ec_i,
    output color_t            pixel_o,
    output logic              pixel_valid_o
);

    color_t     dly_color [3];
    logic [2:0] dly_border;

    // three dots of delay so border edges line up with the pixels
    always_ff @(posedge clk_dot4x) begin
        if (s2_valid_i) begin
            dly_color[0] <= s2_i.color;
            dly_color[1] <= dly_color[0];
            dly_color[2] <= dly_color[1];
            dly_border   <= {dly_border[1:0], s2_i.border};
            pixel_o      <= dly_border[2] ? ec_i : dly_color[2];
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            pixel_valid_o <= 1'b0;
        end else begin
            pixel_valid_o <= s2_valid_i;
        end
    end

endmodule

`default_nettype wire

//--- hdl/sprite_priority_mux.sv
`timescale 1ns/1ns
`default_nettype none

`include "vic_settings.svh"

module sprite_priority_mux import vic_pkg::*; (
    input  wire               clk_dot4x,
    input  wire               rst,
    input  wire color_stage_t s1_i,
    input  wire               s1_valid_i,
    input  wire mode_t        mode_i,
    input  wire sprite_bus_t  sprite_i,
    output color_stage_t      s2_o,
    output logic              s2_valid_o
);

    logic   illegal;
    color_t base_color;
    color_t color_next;

    assign illegal = (mode_i == `MODE_INV_ECM_MC_CHAR) ||
                     (mode_i == `MODE_INV_ECM_STD_BITMAP) ||
                     (mode_i == `MODE_INV_ECM_MC_BITMAP);

    assign base_color = illegal ? `BLACK : s1_i.color;

    // lowest index is applied last and so wins
    always_comb begin
        color_next = base_color;
        for (int n = `NUM_SPRITES - 1; n >= 0; n--) begin
            if (!sprite_i.pri[n] || s1_i.is_background) begin
                if (sprite_i.mmc[n]) begin
                    case (sprite_i.cur_pixel[2*n +: 2])
                        2'b01:   color_next = sprite_i.mc0;
                        2'b10:   color_next = sprite_i.col[`COLOR_W*n +: `COLOR_W];
                        2'b11:   color_next = sprite_i.mc1;
                        default: ;
                    endcase
                end else if (sprite_i.cur_pixel[2*n+1]) begin
                    color_next = sprite_i.col[`COLOR_W*n +: `COLOR_W];
                end
            end
            // behind sprite keeps the foreground even under a lower front sprite
            if (sprite_i.pri[n] && !s1_i.is_background && sprite_i.cur_pixel[2*n+1]) begin
                color_next = base_color;
            end
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (s1_valid_i) begin
            s2_o.color         <= color_next;
            s2_o.is_background <= s1_i.is_background;
            s2_o.border        <= s1_i.border;
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            s2_valid_o <= 1'b0;
        end else begin
            s2_valid_o <= s1_valid_i;
        end
    end

endmodule

`default_nettype wire

//--- hdl/mode_color_decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "vic_settings.svh"

module mode_color_decoder import vic_pkg::*; (
    input  wire               clk_dot4x,
    input  wire               rst,
    input  wire shift_stage_t s0_i,
    input  wire               s0_valid_i,
    input  wire mode_t        mode_i,
    input  wire bg_colors_t   bg_i,
    output color_stage_t      s1_o,
    output logic              s1_valid_o
);

    color_t      color_next;
    logic [1:0]  pair;
    logic [11:0] cw;
    logic        hi;

    assign pair = s0_i.pix_pair;
    assign cw   = s0_i.char_word;
    assign hi   = s0_i.pix_pair[1];

    always_comb begin
        color_next = `BLACK;
        case (mode_i)
            `MODE_STANDARD_CHAR: begin
                color_next = hi ? cw[11:8] : bg_i.b0c;
            end
            `MODE_MULTICOLOR_CHAR: begin
                if (cw[11]) begin
                    case (pair)
                        2'b00:   color_next = bg_i.b0c;
                        2'b01:   color_next = bg_i.b1c;
                        2'b10:   color_next = bg_i.b2c;
                        default: color_next = {1'b0, cw[10:8]};
                    endcase
                end else begin
                    // bit 11 clear falls back to hires
                    color_next = hi ? cw[11:8] : bg_i.b0c;
                end
            end
            `MODE_STANDARD_BITMAP: begin
                color_next = hi ? cw[7:4] : cw[3:0];
            end
            `MODE_MULTICOLOR_BITMAP: begin
                case (pair)
                    2'b00:   color_next = bg_i.b0c;
                    2'b01:   color_next = cw[7:4];
                    2'b10:   color_next = cw[3:0];
                    default: color_next = cw[11:8];
                endcase
            end
            `MODE_EXTENDED_BG_COLOR: begin
                if (hi) begin
                    color_next = cw[11:8];
                end else begin
                    // background picked by char code bits 7:6
                    case (cw[7:6])
                        2'b00:   color_next = bg_i.b0c;
                        2'b01:   color_next = bg_i.b1c;
                        2'b10:   color_next = bg_i.b2c;
                        default: color_next = bg_i.b3c;
                    endcase
                end
            end
            default: color_next = `BLACK;
        endcase
    end

    always_ff @(posedge clk_dot4x) begin
        if (s0_valid_i) begin
            s1_o.color         <= color_next;
            s1_o.is_background <= s0_i.is_background;
            s1_o.border        <= s0_i.border;
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            s1_valid_o <= 1'b0;
        end else begin
            s1_valid_o <= s0_valid_i;
        end
    end

endmodule

`default_nettype wire

//--- hdl/pixel_shifter.sv
`timescale 1ns/1ns
`default_nettype none

`include "vic_settings.svh"

module pixel_shifter import vic_pkg::*; (
    input  wire         clk_dot4x,
    input  wire         rst,
    input  wire         dot_load_i,
    input  wire         dot_shift_i,
    input  wire [2:0]   xpos_i,
    input  wire [6:0]   cycle_num_i,
    input  wire [2:0]   xscroll_i,
    input  wire mode_t  mode_i,
    input  wire         fetch_strobe_i,
    input  wire fetch_t fetch_i,
    input  wire         border_i,
    output shift_stage_t s0_o,
    output logic        s0_valid_o
);

    logic [2:0]  xscroll_q;
    fetch_t      pending_q;
    fetch_t      load_q;
    logic [7:0]  shift_q;
    logic [11:0] char_q;
    logic        mc_phase_q;
    logic        border_q;
    logic        cell_start;
    logic        load_now;
    logic        in_window;
    logic        is_mc;

    assign cell_start = dot_load_i && (xpos_i == 3'd0);
    assign load_now   = (xpos_i == xscroll_q);
    assign in_window  = (cycle_num_i >= `VISIBLE_CYCLE_FIRST) &&
                        (cycle_num_i <= `VISIBLE_CYCLE_LAST);

    // multicolour cell: mcm plus bmm, ecm or char bit 11
    assign is_mc = mode_i[0] & (mode_i[1] | mode_i[2] | char_q[11]);

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            xscroll_q <= 3'd0;
        end else if (cell_start && in_window) begin
            xscroll_q <= xscroll_i;
        end
    end

    // fetch waits in pending until the next cell boundary
    always_ff @(posedge clk_dot4x) begin
        if (fetch_strobe_i) begin
            pending_q <= fetch_i;
        end
        if (cell_start) begin
            load_q <= pending_q;
        end
        if (dot_shift_i) begin
            border_q <= border_i;
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            shift_q    <= 8'd0;
            char_q     <= 12'd0;
            mc_phase_q <= 1'b0;
            s0_valid_o <= 1'b0;
        end else begin
            s0_valid_o <= dot_shift_i;
            if (dot_shift_i) begin
                if (load_now) begin
                    shift_q    <= load_q.pixels;
                    char_q     <= load_q.char_word;
                    mc_phase_q <= 1'b0;
                end else if (is_mc) begin
                    // each pair is shown for two dots
                    if (mc_phase_q) begin
                        shift_q <= {shift_q[5:0], 2'b00};
                    end
                    mc_phase_q <= ~mc_phase_q;
                end else begin
                    shift_q <= {shift_q[6:0], 1'b0};
                end
            end
        end
    end

    always_comb begin
        s0_o.pix_pair      = shift_q[7:6];
        s0_o.char_word     = char_q;
        s0_o.is_background = ~shift_q[7];
        s0_o.border        = border_q;
    end

endmodule

`default_nettype wire

//--- hdl/dot_timing.sv
`timescale 1ns/1ns
`default_nettype none

module dot_timing import vic_pkg::*; (
    input  wire  clk_dot4x,
    input  wire  rst,
    output logic dot_load_o,
    output logic dot_shift_o,
    output logic [2:0] xpos_o
);

    dot_phase_e phase_q;
    dot_phase_e phase_next;

    // four clk_dot4x cycles per dot
    always_comb begin
        case (phase_q)
            PH0:     phase_next = PH1;
            PH1:     phase_next = PH2;
            PH2:     phase_next = PH3;
            default: phase_next = PH0;
        endcase
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            phase_q     <= PH0;
            dot_load_o  <= 1'b0;
            dot_shift_o <= 1'b0;
            xpos_o      <= 3'd0;
        end else begin
            phase_q     <= phase_next;
            // strobes are high while the phase register holds PH0 / PH1
            dot_load_o  <= (phase_next == PH0);
            dot_shift_o <= (phase_next == PH1);
            // next dot starts on the PH3 to PH0 step
            if (phase_q == PH3) begin
                xpos_o <= xpos_o + 3'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/vic_pkg.sv
`default_nettype none

`include "vic_settings.svh"

package vic_pkg;

    typedef logic [`COLOR_W-1:0] color_t;

    // {ecm, bmm, mcm}
    typedef logic [2:0] mode_t;

    // char_word: colour nibble 11:8, upper 7:4, lower 3:0
    typedef struct packed {
        logic [7:0]  pixels;
        logic [11:0] char_word;
    } fetch_t;

    typedef struct packed {
        color_t b0c;
        color_t b1c;
        color_t b2c;
        color_t b3c;
    } bg_colors_t;

    // sprite n occupies cur_pixel[2n+1:2n] and col[4n+3:4n]
    typedef struct packed {
        logic [`NUM_SPRITES*2-1:0]        cur_pixel;
        logic [`NUM_SPRITES-1:0]          pri;
        logic [`NUM_SPRITES-1:0]          mmc;
        logic [`NUM_SPRITES*`COLOR_W-1:0] col;
        color_t                           mc0;
        color_t                           mc1;
    } sprite_bus_t;

    typedef struct packed {
        logic [1:0]  pix_pair;
        logic [11:0] char_word;
        logic        is_background;
        logic        border;
    } shift_stage_t;

    typedef struct packed {
        color_t color;
        logic   is_background;
        logic   border;
    } color_stage_t;

    typedef enum logic [1:0] {
        PH0,
        PH1,
        PH2,
        PH3
    } dot_phase_e;

endpackage

`default_nettype wire

//--- hdl/vic_settings.svh
`ifndef VIC_SETTINGS_SVH
`define VIC_SETTINGS_SVH

// fixed by the chip
`define NUM_SPRITES 8
`define COLOR_W 4

`define BLACK 4'd0

// display mode codes, bit order {ecm, bmm, mcm}
`define MODE_STANDARD_CHAR      3'b000
`define MODE_MULTICOLOR_CHAR    3'b001
`define MODE_STANDARD_BITMAP    3'b010
`define MODE_MULTICOLOR_BITMAP  3'b011
`define MODE_EXTENDED_BG_COLOR  3'b100
`define MODE_INV_ECM_MC_CHAR    3'b101
`define MODE_INV_ECM_STD_BITMAP 3'b110
`define MODE_INV_ECM_MC_BITMAP  3'b111

// cycles in which the scroll register may be picked up
`define VISIBLE_CYCLE_FIRST 7'd15
`define VISIBLE_CYCLE_LAST  7'd55

`endif
